/* files.f */
verilog/bch_synd_pkg.sv
verilog/gf_mult.sv
verilog/input_delay_line.sv
verilog/bit_weight_tree.sv
verilog/syndrome_lane.sv
verilog/syndrome_bank.sv
verif/tb_clock_gen.sv
verif/syndrome_bank_assert.sv
verif/syndrome_bank_tb.sv

/* Bender.yml */
package:
  name: syndrome_bank

sources:
  # design
  - files:
      - verilog/bch_synd_pkg.sv
      - verilog/gf_mult.sv
      - verilog/input_delay_line.sv
      - verilog/bit_weight_tree.sv
      - verilog/syndrome_lane.sv
      - verilog/syndrome_bank.sv

  # testbench
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/syndrome_bank_assert.sv
      - verif/syndrome_bank_tb.sv

/* verif/syndrome_bank_tb.sv */
/*
 * Testbench for syndrome_bank. Random groups from a fixed seed are driven
 * through the DUT and every output is compared with a behavioural model.
 */
`timescale 1ns/1ps
`default_nettype none

module syndrome_bank_tb;
    import bch_synd_pkg::*;

    localparam int PARALLELISM  = 4;
    localparam int NUM_SYND     = 4;
    localparam int BUF_STAGES   = 2;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 99;

    // block lengths in groups
    localparam int LEN_SINGLE = 12;
    localparam int LEN_B2B    = 10;
    localparam int LEN_PRE    = 4;
    localparam int LEN_POST   = 8;
    localparam int LEN_HOLD_A = 5;
    localparam int LEN_HOLD_C = 4;
    localparam int BLOCK_SUM  = 2 * (LEN_SINGLE + 1) + 2 * (LEN_B2B + 1)
                              + LEN_PRE + 1 + LEN_POST + LEN_HOLD_A + 1 + LEN_HOLD_C;
    localparam int TIMEOUT_CYCLES = 2 * BLOCK_SUM + 200;

    // x^10 + x^3 + 1
    localparam logic [GF_LEN:0] FIELD_POLY = 11'h409;
    localparam int PROD_W = 2 * GF_LEN - 1;

    typedef logic [PARALLELISM-1:0] group_t;
    typedef group_t group_q_t [$];
    typedef gf_elem_t synd_arr_t [NUM_SYND];

    typedef struct packed {
        synd_ctrl_t ctrl;
        group_t     bits;
    } stage_t;

    logic       clk;
    logic       in_ctr_Srst;
    synd_ctrl_t ctrl;
    group_t     bits;
    synd_arr_t  syndromes;

    // model state
    stage_t     pipe_q [$];
    gf_elem_t   model_acc [NUM_SYND];
    synd_arr_t  model_synd;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    tb_clock_gen #(
        .PERIOD_NS(CLK_PERIOD)
    ) u_clock_gen (
        .clk(clk)
    );

    syndrome_bank #(
        .PARALLELISM(PARALLELISM),
        .NUM_SYND   (NUM_SYND),
        .BUF_STAGES (BUF_STAGES)
    ) i_syndrome_bank (
        .clk        (clk),
        .in_ctr_Srst(in_ctr_Srst),
        .ctrl       (ctrl),
        .bits       (bits),
        .syndromes  (syndromes)
    );

    bind syndrome_lane syndrome_bank_assert u_lane_assert (
        .clk        (clk),
        .in_ctr_Srst(in_ctr_Srst),
        .ctrl       (ctrl),
        .accum_q    (accum_q),
        .synd_q     (synd_q)
    );

    // full polynomial product reduced from the top term down
    function automatic gf_elem_t field_mul(gf_elem_t a, gf_elem_t b);
        logic [PROD_W-1:0] prod;
        prod = '0;
        for (int i = 0; i < GF_LEN; i++) begin
            if (b[i]) begin
                prod = prod ^ (PROD_W'(a) << i);
            end
        end
        for (int d = PROD_W - 1; d >= GF_LEN; d--) begin
            if (prod[d]) begin
                prod = prod ^ (PROD_W'(FIELD_POLY) << (d - GF_LEN));
            end
        end
        return prod[GF_LEN-1:0];
    endfunction

    // bit i weighted by seed * alpha^-(k*(P-1-i))
    function automatic gf_elem_t group_term(int k, group_t g);
        gf_elem_t sum;
        sum = '0;
        for (int i = 0; i < PARALLELISM; i++) begin
            if (g[i]) begin
                sum = sum ^ gf_mul_alpha_inv(BIT_WEIGHT_SEED, k * (PARALLELISM - 1 - i));
            end
        end
        return sum;
    endfunction

    function automatic gf_elem_t horner_step(int k, gf_elem_t acc, group_t g);
        gf_elem_t step;
        step = gf_mul_alpha_inv(gf_elem_t'(1), k * PARALLELISM);
        return group_term(k, g) ^ field_mul(acc, step);
    endfunction

    // syndromes of a block evaluated from a cleared accumulator
    function automatic synd_arr_t block_result(group_q_t groups);
        synd_arr_t res;
        for (int s = 0; s < NUM_SYND; s++) begin
            res[s] = '0;
            foreach (groups[g]) begin
                res[s] = horner_step(s + 1, res[s], groups[g]);
            end
        end
        return res;
    endfunction

    function automatic synd_ctrl_t make_ctrl(logic en, logic sc_en, logic init, logic done);
        synd_ctrl_t c;
        c.en    = en;
        c.sc_en = sc_en;
        c.init  = init;
        c.done  = done;
        return c;
    endfunction

    task automatic model_reset();
        pipe_q.delete();
        for (int s = 0; s < BUF_STAGES; s++) begin
            pipe_q.push_back('0);
        end
        for (int s = 0; s < NUM_SYND; s++) begin
            model_acc[s]  = '0;
            model_synd[s] = '0;
        end
    endtask

    // one rising edge as the DUT sees it
    task automatic model_edge(synd_ctrl_t c, group_t b);
        stage_t   head;
        gf_elem_t nxt;
        if (c.en) begin
            pipe_q.push_back({c, b});
            head = pipe_q.pop_front();
            if (head.ctrl.en) begin
                for (int s = 0; s < NUM_SYND; s++) begin
                    nxt = horner_step(s + 1, model_acc[s], head.bits);
                    if (head.ctrl.done) begin
                        model_synd[s] = nxt;
                    end
                    if (head.ctrl.init) begin
                        model_acc[s] = '0;
                    end else if (head.ctrl.sc_en) begin
                        model_acc[s] = nxt;
                    end
                end
            end
        end
    endtask

    task automatic compare_elem(string name, gf_elem_t got, gf_elem_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns %s: got %03h, expected %03h", $time, name, got, exp);
        end
    endtask

    task automatic compare_all(string tag, synd_arr_t got, synd_arr_t exp);
        for (int s = 0; s < NUM_SYND; s++) begin
            compare_elem($sformatf("%s syndromes[%0d]", tag, s), got[s], exp[s]);
        end
    endtask

    // drive one cycle and check the model after the edge
    task automatic drive_cycle(synd_ctrl_t c, group_t b);
        ctrl = c;
        bits = b;
        model_edge(c, b);
        @(posedge clk);
        #DRIVE_DELAY;
        compare_all("cycle", syndromes, model_synd);
    endtask

    // en-low cycles with junk on the other inputs
    task automatic maybe_stall(int gap_pct);
        synd_ctrl_t junk;
        int         n;
        if ($urandom_range(99) < gap_pct) begin
            n = $urandom_range(3, 1);
            repeat (n) begin
                junk    = synd_ctrl_t'($urandom);
                junk.en = 1'b0;
                drive_cycle(junk, group_t'($urandom));
            end
        end
    endtask

    task automatic send_init(int gap_pct);
        maybe_stall(gap_pct);
        drive_cycle(make_ctrl(1'b1, 1'b0, 1'b1, 1'b0), group_t'($urandom));
    endtask

    task automatic send_groups(group_q_t groups, logic with_done, int gap_pct);
        foreach (groups[g]) begin
            maybe_stall(gap_pct);
            drive_cycle(make_ctrl(1'b1, 1'b1, 1'b0, with_done && (g == groups.size() - 1)),
                        groups[g]);
        end
    endtask

    // enabled idle cycles push the last groups out of the delay line
    task automatic flush_pipe(int gap_pct);
        repeat (BUF_STAGES + 1) begin
            maybe_stall(gap_pct);
            drive_cycle(make_ctrl(1'b1, 1'b0, 1'b0, 1'b0), group_t'($urandom));
        end
    endtask

    task automatic random_groups(output group_q_t groups, input int n);
        groups.delete();
        repeat (n) begin
            groups.push_back(group_t'($urandom));
        end
    endtask

    initial begin
        synd_arr_t   zeros;
        synd_arr_t   single_res;
        group_q_t    grp_a;
        group_q_t    grp_b;
        group_q_t    grp_c;
        group_t      hold_bits;

        void'($urandom(SEED));
        ctrl        = '0;
        bits        = '0;
        in_ctr_Srst = 1'b1;
        model_reset();
        foreach (zeros[s]) begin
            zeros[s] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        in_ctr_Srst = 1'b0;

        // outputs stay zero until the first done
        compare_all("after reset", syndromes, zeros);
        repeat (6) begin
            drive_cycle(make_ctrl(1'($urandom), 1'b1, 1'b0, 1'b0), group_t'($urandom));
        end
        compare_all("before first done", syndromes, zeros);

        // single block
        random_groups(grp_a, LEN_SINGLE);
        send_init(0);
        send_groups(grp_a, 1'b1, 0);
        flush_pipe(0);
        single_res = block_result(grp_a);
        compare_all("single block", syndromes, single_res);

        // same block with stalls and one forced while init sits in the line
        send_init(40);
        maybe_stall(100);
        send_groups(grp_a, 1'b1, 40);
        flush_pipe(40);
        compare_all("stalled block", syndromes, single_res);

        // back-to-back blocks with init right after done
        random_groups(grp_a, LEN_B2B);
        random_groups(grp_b, LEN_B2B);
        send_init(0);
        send_groups(grp_a, 1'b1, 0);
        send_init(0);
        send_groups(grp_b, 1'b1, 0);
        // second done still in the delay line here
        compare_all("first of two blocks", syndromes, block_result(grp_a));
        flush_pipe(0);
        compare_all("second of two blocks", syndromes, block_result(grp_b));

        // init mid-block drops earlier groups
        random_groups(grp_a, LEN_PRE);
        random_groups(grp_b, LEN_POST);
        send_init(20);
        send_groups(grp_a, 1'b0, 20);
        send_init(20);
        send_groups(grp_b, 1'b1, 20);
        flush_pipe(20);
        compare_all("mid-block init", syndromes, block_result(grp_b));

        // done without sc_en captures the next value while the accumulator holds
        random_groups(grp_a, LEN_HOLD_A);
        random_groups(grp_c, LEN_HOLD_C);
        hold_bits = group_t'($urandom);
        send_init(0);
        send_groups(grp_a, 1'b0, 0);
        drive_cycle(make_ctrl(1'b1, 1'b0, 1'b0, 1'b1), hold_bits);
        flush_pipe(0);
        grp_b = grp_a;
        grp_b.push_back(hold_bits);
        compare_all("done without sc_en", syndromes, block_result(grp_b));
        send_groups(grp_c, 1'b1, 0);
        flush_pipe(0);
        foreach (grp_c[g]) begin
            grp_a.push_back(grp_c[g]);
        end
        compare_all("held accumulator", syndromes, block_result(grp_a));

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // run limit
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/syndrome_bank_assert.sv */
/*
 * Concurrent checks on the registers of one syndrome lane.
 * The testbench binds this module into every syndrome_lane instance.
 */
`timescale 1ns/1ps
`default_nettype none

module syndrome_bank_assert (
    input logic                     clk,
    input logic                     in_ctr_Srst,
    input bch_synd_pkg::synd_ctrl_t ctrl,
    input bch_synd_pkg::gf_elem_t   accum_q,
    input bch_synd_pkg::gf_elem_t   synd_q
);
    import bch_synd_pkg::*;

    // output register moves only after a sampled en with done
    property p_synd_on_done;
        @(posedge clk) disable iff (in_ctr_Srst)
            !$stable(synd_q) |-> $past(ctrl.en && ctrl.done);
    endproperty

    // init clears the running value
    property p_init_clears;
        @(posedge clk) disable iff (in_ctr_Srst)
            (ctrl.en && ctrl.init) |=> (accum_q == gf_elem_t'(0));
    endproperty

    property p_reset_clears;
        @(posedge clk) in_ctr_Srst |=> (accum_q == gf_elem_t'(0) && synd_q == gf_elem_t'(0));
    endproperty

    a_synd_on_done: assert property (p_synd_on_done)
        else $error("syndrome register changed without a sampled en and done");

    a_init_clears: assert property (p_init_clears)
        else $error("accumulator not zero in the cycle after en with init");

    a_reset_clears: assert property (p_reset_clears)
        else $error("lane registers not zero after reset");

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/*
 * Free-running testbench clock with a 50% duty cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verilog/syndrome_bank.sv */
/*
 * Top level of the syndrome bank: an optional input delay line followed by
 * NUM_SYND lanes computing S_1 .. S_NUM_SYND in parallel.
 */
`timescale 1ns/1ps
`default_nettype none

module syndrome_bank #(
    parameter int PARALLELISM = 4,
    parameter int NUM_SYND    = 4,
    parameter int BUF_STAGES  = 2
) (
    input  logic                     clk,
    input  logic                     in_ctr_Srst,
    input  bch_synd_pkg::synd_ctrl_t ctrl,
    input  logic [PARALLELISM-1:0]   bits,
    output bch_synd_pkg::gf_elem_t   syndromes [NUM_SYND]
);
    import bch_synd_pkg::*;

    // controls and bits travel as one word through the delay line
    typedef struct packed {
        synd_ctrl_t             ctrl;
        logic [PARALLELISM-1:0] bits;
    } payload_t;

    payload_t   payload_in;
    payload_t   payload_dly;
    synd_ctrl_t lane_ctrl;

    assign payload_in.ctrl = ctrl;
    assign payload_in.bits = bits;

    input_delay_line #(
        .BUF_STAGES(BUF_STAGES),
        .payload_t (payload_t)
    ) u_delay_line (
        .clk        (clk),
        .in_ctr_Srst(in_ctr_Srst),
        .shift_en   (ctrl.en),
        .din        (payload_in),
        .dout       (payload_dly)
    );

    // a stalled cycle must not re-apply the group held at the line output,
    // so lanes only act when the raw enable is high as well
    always_comb begin
        lane_ctrl    = payload_dly.ctrl;
        lane_ctrl.en = payload_dly.ctrl.en & ctrl.en;
    end

    generate
        for (genvar k = 0; k < NUM_SYND; k++) begin : gen_lane
            syndrome_lane #(
                .PARALLELISM(PARALLELISM),
                .SYND_INDEX (k + 1)
            ) u_lane (
                .clk        (clk),
                .in_ctr_Srst(in_ctr_Srst),
                .ctrl       (lane_ctrl),
                .bits       (payload_dly.bits),
                .syndrome   (syndromes[k])
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* verilog/syndrome_lane.sv */
/*
 * One syndrome S_k: Horner accumulator over groups of PARALLELISM bits
 * plus the captured output register. Driven by init / sc_en / done strobes.
 */
`timescale 1ns/1ps
`default_nettype none

module syndrome_lane #(
    parameter int PARALLELISM = 4,
    parameter int SYND_INDEX  = 1
) (
    input  logic                    clk,
    input  logic                    in_ctr_Srst,
    input  bch_synd_pkg::synd_ctrl_t ctrl,
    input  logic [PARALLELISM-1:0]  bits,
    output bch_synd_pkg::gf_elem_t  syndrome
);
    import bch_synd_pkg::*;

    // feedback scale per group, alpha^-(k * PARALLELISM)
    localparam gf_elem_t STEP = gf_alpha_inv_pow(SYND_INDEX * PARALLELISM);

    gf_elem_t weight_sum;
    gf_elem_t step_prod;
    gf_elem_t next_val;
    gf_elem_t accum_q;
    gf_elem_t synd_q;

    bit_weight_tree #(
        .PARALLELISM(PARALLELISM),
        .SYND_INDEX (SYND_INDEX)
    ) u_weight_tree (
        .bits      (bits),
        .weight_sum(weight_sum)
    );

    gf_mult u_step_mult (
        .a      (accum_q),
        .b      (STEP),
        .product(step_prod)
    );

    // new group folded onto the scaled running value
    assign next_val = weight_sum ^ step_prod;

    // init wins over sc_en
    always_ff @(posedge clk) begin
        if (in_ctr_Srst) begin
            accum_q <= '0;
        end else if (ctrl.en) begin
            if (ctrl.init) begin
                accum_q <= '0;
            end else if (ctrl.sc_en) begin
                accum_q <= next_val;
            end
        end
    end

    // done takes next_val, so the last group may arrive with done
    always_ff @(posedge clk) begin
        if (in_ctr_Srst) begin
            synd_q <= '0;
        end else if (ctrl.en && ctrl.done) begin
            synd_q <= next_val;
        end
    end

    assign syndrome = synd_q;

endmodule

`default_nettype wire

/* verilog/bit_weight_tree.sv */
/*
 * Weights each received bit by its constant alpha power and XOR-reduces
 * the terms to one field element. Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module bit_weight_tree #(
    parameter int PARALLELISM = 4,
    parameter int SYND_INDEX  = 1
) (
    input  logic [PARALLELISM-1:0] bits,
    output bch_synd_pkg::gf_elem_t weight_sum
);
    import bch_synd_pkg::*;

    // nodes of a binary tree in heap order
    // node 0 is the root, leaves sit at PARALLELISM-1 .. 2*PARALLELISM-2
    localparam int NUM_NODES = 2 * PARALLELISM - 1;

    gf_elem_t node [NUM_NODES];

    generate
        // leaves, each bit gated onto its folded weight
        for (genvar i = 0; i < PARALLELISM; i++) begin : gen_leaf
            // bit i is followed by PARALLELISM-1-i newer bits in its group,
            // so it is scaled down by alpha^-k once per later position
            localparam gf_elem_t WEIGHT = gf_mul_alpha_inv(
                BIT_WEIGHT_SEED,
                gf_exp_reduce(SYND_INDEX * (PARALLELISM - 1 - i))
            );

            assign node[PARALLELISM-1+i] = {GF_LEN{bits[i]}} & WEIGHT;
        end

        // inner nodes, each the sum of its two children
        // with a single bit there are no inner nodes and the leaf is the root
        for (genvar j = 0; j < PARALLELISM - 1; j++) begin : gen_node
            assign node[j] = node[2*j+1] ^ node[2*j+2];
        end
    endgenerate

    assign weight_sum = node[0];

endmodule

`default_nettype wire

/* verilog/input_delay_line.sv */
/*
 * Enable-gated shift register that delays controls and data together.
 * BUF_STAGES = 0 turns it into plain wiring.
 */
`timescale 1ns/1ps
`default_nettype none

module input_delay_line #(
    parameter int  BUF_STAGES = 2,
    parameter type payload_t  = logic
) (
    input  logic     clk,
    input  logic     in_ctr_Srst,
    input  logic     shift_en,
    input  payload_t din,
    output payload_t dout
);

    generate
        if (BUF_STAGES == 0) begin : gen_bypass
            // no buffering requested
            assign dout = din;
        end else begin : gen_stages
            payload_t stage_q [BUF_STAGES];

            // whole chain moves only on enabled cycles, so groups in flight
            // keep their spacing across stalls
            always_ff @(posedge clk) begin
                if (in_ctr_Srst) begin
                    for (int s = 0; s < BUF_STAGES; s++) begin
                        stage_q[s] <= '0;
                    end
                end else if (shift_en) begin
                    stage_q[0] <= din;
                    for (int s = 1; s < BUF_STAGES; s++) begin
                        stage_q[s] <= stage_q[s-1];
                    end
                end
            end

            // oldest entry
            assign dout = stage_q[BUF_STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* verilog/gf_mult.sv */
/*
 * Combinational GF(2^10) multiplier, reduced by x^10 + x^3 + 1.
 * Used as the constant-step feedback multiplier of each lane.
 */
`timescale 1ns/1ps
`default_nettype none

module gf_mult (
    input  bch_synd_pkg::gf_elem_t a,
    input  bch_synd_pkg::gf_elem_t b,
    output bch_synd_pkg::gf_elem_t product
);
    import bch_synd_pkg::*;

    // low terms of the field polynomial, x^10 = x^3 + 1
    // rebuilt from the alpha^-1 constant so the polynomial lives in one place
    localparam gf_elem_t REDUCE = gf_elem_t'({FIELD_SHIFT_BACK, 1'b1});

    // shift-and-add over the bits of b, msb first (Horner in alpha)
    always_comb begin
        gf_elem_t acc;
        acc = '0;
        for (int i = GF_LEN - 1; i >= 0; i--) begin
            // acc * alpha
            if (acc[GF_LEN-1]) begin
                acc = (acc << 1) ^ REDUCE;
            end else begin
                acc = acc << 1;
            end
            // add a where b has a term
            if (b[i]) begin
                acc = acc ^ a;
            end
        end
        product = acc;
    end

endmodule

`default_nettype wire

/* verilog/bch_synd_pkg.sv */
/*
 * Shared field constants, types and elaboration-time helpers for the
 * GF(2^10) BCH syndrome bank. Modules import it inside their bodies.
 */
`default_nettype none

package bch_synd_pkg;

    // field is GF(2^10), polynomial x^10 + x^3 + 1
    localparam int GF_LEN = 10;

    typedef logic [GF_LEN-1:0] gf_elem_t;

    // alpha^-1 = alpha^9 + alpha^2, folded in after a right shift
    // whenever the bit shifted out was set
    localparam gf_elem_t FIELD_SHIFT_BACK = 10'd516;

    // weight of the last bit of a group for lane index 0
    localparam gf_elem_t BIT_WEIGHT_SEED = 10'd580;

    // per-cycle qualifiers, sampled on every rising edge
    typedef struct packed {
        logic en;
        logic sc_en;
        logic init;
        logic done;
    } synd_ctrl_t;

    // multiply by alpha^-1 once
    function automatic gf_elem_t gf_alpha_inv_once(gf_elem_t value);
        gf_elem_t shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ FIELD_SHIFT_BACK;
        end
        return shifted;
    endfunction

    // value * alpha^(-count)
    // meant for constant folding, the loop length is not bounded in hardware
    function automatic gf_elem_t gf_mul_alpha_inv(gf_elem_t value, int unsigned count);
        gf_elem_t result;
        result = value;
        for (int unsigned n = 0; n < count; n++) begin
            result = gf_alpha_inv_once(result);
        end
        return result;
    endfunction

    // order of alpha is 2^10 - 1, so large exponents can be reduced first
    // to keep elaboration loops short
    localparam int unsigned GF_ORDER = (1 << GF_LEN) - 1;

    function automatic int unsigned gf_exp_reduce(int unsigned exponent);
        return exponent % GF_ORDER;
    endfunction

    // constant alpha^(-exponent), with the exponent reduced mod the group order
    function automatic gf_elem_t gf_alpha_inv_pow(int unsigned exponent);
        gf_elem_t one;
        one = gf_elem_t'(1);
        return gf_mul_alpha_inv(one, gf_exp_reduce(exponent));
    endfunction

endpackage

`default_nettype wire
